//--- common/perf_macros.svh
`ifndef PERF_MACROS_SVH
`define PERF_MACROS_SVH

// width of every event counter and of the two access sums
`define PERF_CNT_W 12

// clock cycles from one report strobe to the next
`define PERF_REPORT_PERIOD 120

// tag plus six hex digits, three groups
`define PERF_RECORD_LEN 21

// hex digits printed per counter value
`define PERF_HEX_DIGITS 3

// ascii tag letters, one per group
`define PERF_TAG_L1I 8'h61
`define PERF_TAG_L1D 8'h62
`define PERF_TAG_L2 8'h63

`endif

//--- common/perf_pkg.sv
`default_nettype none

`include "perf_macros.svh"

package perf_pkg;

	// raw event lines from the cache, level signals
	typedef struct packed {
		logic l1i_read;
		logic l1i_miss;
		logic l1d_read;
		logic l1d_write;
		logic l1d_miss;
		logic l2_read;
		logic l2_write;
		logic l2_miss;
	} cache_events_t;

	// cumulative rising-edge counts, same field order as the events
	typedef struct packed {
		logic [`PERF_CNT_W-1:0] l1i_read;
		logic [`PERF_CNT_W-1:0] l1i_miss;
		logic [`PERF_CNT_W-1:0] l1d_read;
		logic [`PERF_CNT_W-1:0] l1d_write;
		logic [`PERF_CNT_W-1:0] l1d_miss;
		logic [`PERF_CNT_W-1:0] l2_read;
		logic [`PERF_CNT_W-1:0] l2_write;
		logic [`PERF_CNT_W-1:0] l2_miss;
	} perf_counts_t;

	// one byte towards the sink, no ready
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} report_beat_t;

endpackage

`default_nettype wire

//--- perf_report/report_formatter.sv
`default_nettype none

`include "perf_macros.svh"

module report_formatter (
	input  wire                    clk,
	input  wire                    rstn,
	input  logic                   report_strobe_i,
	input  perf_pkg::perf_counts_t  counts_i,
	output perf_pkg::report_beat_t  beat_o
);

	localparam int IDX_W = $clog2(`PERF_RECORD_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`PERF_RECORD_LEN - 1);

	// snapshot taken at the strobe
	logic [`PERF_CNT_W-1:0] l1i_miss_q;
	logic [`PERF_CNT_W-1:0] l1i_read_q;
	logic [`PERF_CNT_W-1:0] l1d_miss_q;
	logic [`PERF_CNT_W-1:0] l1d_acc_q;
	logic [`PERF_CNT_W-1:0] l2_miss_q;
	logic [`PERF_CNT_W-1:0] l2_acc_q;

	// index of the byte sent next, 0 when idle
	logic [IDX_W-1:0] idx_q;
	logic [7:0]       rec_byte;

	function automatic logic [7:0] hex_char(input logic [3:0] nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib};
		return 8'h41 + {4'h0, nib - 4'd10};
	endfunction

	// pos 0 is the least significant digit
	function automatic logic [7:0] digit(
		input logic [`PERF_CNT_W-1:0] val,
		input int unsigned            pos
	);
		return hex_char(val[4*pos +: 4]);
	endfunction

	// sums are cut to counter width on purpose
	always_ff @(posedge clk) begin
		if (report_strobe_i) begin
			l1i_miss_q <= counts_i.l1i_miss;
			l1i_read_q <= counts_i.l1i_read;
			l1d_miss_q <= counts_i.l1d_miss;
			l1d_acc_q  <= counts_i.l1d_read + counts_i.l1d_write;
			l2_miss_q  <= counts_i.l2_miss;
			l2_acc_q   <= counts_i.l2_read + counts_i.l2_write;
		end
	end

	// record layout, miss then access, msd first
	always_comb begin
		case (idx_q)
			5'd0:    rec_byte = `PERF_TAG_L1I;
			5'd1:    rec_byte = digit(l1i_miss_q, 2);
			5'd2:    rec_byte = digit(l1i_miss_q, 1);
			5'd3:    rec_byte = digit(l1i_miss_q, 0);
			5'd4:    rec_byte = digit(l1i_read_q, 2);
			5'd5:    rec_byte = digit(l1i_read_q, 1);
			5'd6:    rec_byte = digit(l1i_read_q, 0);
			5'd7:    rec_byte = `PERF_TAG_L1D;
			5'd8:    rec_byte = digit(l1d_miss_q, 2);
			5'd9:    rec_byte = digit(l1d_miss_q, 1);
			5'd10:   rec_byte = digit(l1d_miss_q, 0);
			5'd11:   rec_byte = digit(l1d_acc_q, 2);
			5'd12:   rec_byte = digit(l1d_acc_q, 1);
			5'd13:   rec_byte = digit(l1d_acc_q, 0);
			5'd14:   rec_byte = `PERF_TAG_L2;
			5'd15:   rec_byte = digit(l2_miss_q, 2);
			5'd16:   rec_byte = digit(l2_miss_q, 1);
			5'd17:   rec_byte = digit(l2_miss_q, 0);
			5'd18:   rec_byte = digit(l2_acc_q, 2);
			5'd19:   rec_byte = digit(l2_acc_q, 1);
			5'd20:   rec_byte = digit(l2_acc_q, 0);
			default: rec_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			idx_q  <= '0;
			beat_o <= '0;
		end else if (report_strobe_i) begin
			// idx is 0 here, so this is the first tag
			beat_o.valid <= 1'b1;
			beat_o.data  <= rec_byte;
			idx_q        <= IDX_W'(1);
		end else if (idx_q != '0) begin
			beat_o.valid <= 1'b1;
			beat_o.data  <= rec_byte;
			if (idx_q == LAST_IDX)
				idx_q <= '0;
			else
				idx_q <= idx_q + 1'b1;
		end else begin
			beat_o.valid <= 1'b0;
			beat_o.data  <= 8'h00;
		end
	end

	// sink cannot stall, so a new strobe must wait for the record to end
	a_no_overlap: assert property (
		@(posedge clk) disable iff (!rstn)
		report_strobe_i |-> (idx_q == '0)
	);

	a_record_len: assert property (
		@(posedge clk) disable iff (!rstn)
		$rose(beat_o.valid) |-> beat_o.valid [*`PERF_RECORD_LEN] ##1 !beat_o.valid
	);

	a_period_fits: assert property (
		@(posedge clk) disable iff (!rstn)
		`PERF_REPORT_PERIOD > `PERF_RECORD_LEN
	);

endmodule

`default_nettype wire

//--- rtl/cache_perf_monitor.sv
`default_nettype none

module cache_perf_monitor (
	input  wire                    clk,
	input  wire                    rstn,
	input  perf_pkg::cache_events_t events_i,
	output perf_pkg::report_beat_t  beat_o
);

	import perf_pkg::*;

	perf_counts_t counts;
	logic         report_strobe;

	// free-running edge counters
	event_counter_bank event_counter_bank_inst (
		.clk      (clk),
		.rstn     (rstn),
		.events_i (events_i),
		.counts_o (counts)
	);

	report_timer report_timer_inst (
		.clk             (clk),
		.rstn            (rstn),
		.report_strobe_o (report_strobe)
	);

	// one record per strobe, 21 cycles long
	report_formatter report_formatter_inst (
		.clk             (clk),
		.rstn            (rstn),
		.report_strobe_i (report_strobe),
		.counts_i        (counts),
		.beat_o          (beat_o)
	);

endmodule

`default_nettype wire

//--- rtl/event_counter_bank.sv
`default_nettype none

`include "perf_macros.svh"

module event_counter_bank (
	input  wire                    clk,
	input  wire                    rstn,
	input  perf_pkg::cache_events_t events_i,
	output perf_pkg::perf_counts_t  counts_o
);

	import perf_pkg::*;

	cache_events_t prev_q;
	cache_events_t rise;

	// one cycle old sample of every line
	always_ff @(posedge clk) begin
		if (!rstn) begin
			prev_q <= '0;
		end else begin
			prev_q <= events_i;
		end
	end

	// high only on the first sample of a high level
	assign rise = events_i & ~prev_q;

	function automatic logic [`PERF_CNT_W-1:0] bump(
		input logic [`PERF_CNT_W-1:0] cnt,
		input logic                   hit
	);
		if (hit)
			return cnt + 1'b1;
		return cnt;
	endfunction

	// counters wrap silently at the top
	always_ff @(posedge clk) begin
		if (!rstn) begin
			counts_o <= '0;
		end else begin
			counts_o.l1i_read  <= bump(counts_o.l1i_read, rise.l1i_read);
			counts_o.l1i_miss  <= bump(counts_o.l1i_miss, rise.l1i_miss);
			counts_o.l1d_read  <= bump(counts_o.l1d_read, rise.l1d_read);
			counts_o.l1d_write <= bump(counts_o.l1d_write, rise.l1d_write);
			counts_o.l1d_miss  <= bump(counts_o.l1d_miss, rise.l1d_miss);
			counts_o.l2_read   <= bump(counts_o.l2_read, rise.l2_read);
			counts_o.l2_write  <= bump(counts_o.l2_write, rise.l2_write);
			counts_o.l2_miss   <= bump(counts_o.l2_miss, rise.l2_miss);
		end
	end

endmodule

`default_nettype wire

//--- rtl/report_timer.sv
`default_nettype none

`include "perf_macros.svh"

module report_timer (
	input  wire  clk,
	input  wire  rstn,
	output logic report_strobe_o
);

	localparam int CNT_W = $clog2(`PERF_REPORT_PERIOD);
	localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(`PERF_REPORT_PERIOD - 1);

	logic [CNT_W-1:0] cycle_q;
	logic             wrap;

	assign wrap = (cycle_q == LAST_CYCLE);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			cycle_q         <= '0;
			report_strobe_o <= 1'b0;
		end else begin
			if (wrap)
				cycle_q <= '0;
			else
				cycle_q <= cycle_q + 1'b1;
			// strobe sits in the cycle after the wrap
			report_strobe_o <= wrap;
		end
	end

	a_strobe_single: assert property (
		@(posedge clk) disable iff (!rstn)
		report_strobe_o |=> !report_strobe_o
	);

endmodule

`default_nettype wire

//--- src.f
+incdir+common
common/perf_pkg.sv
rtl/event_counter_bank.sv
rtl/report_timer.sv
perf_report/report_formatter.sv
rtl/cache_perf_monitor.sv
tests/perf_checker.sv
tests/tb_cache_perf_monitor.sv

//--- tests/perf_checker.sv
`default_nettype none

`include "perf_macros.svh"

module perf_checker (
	input  wire                     clk,
	input  wire                     rstn,
	input  perf_pkg::cache_events_t events_i,
	input  perf_pkg::report_beat_t  beat_i,
	output logic                    done_o,
	output int unsigned             fail_cnt_o
);

	timeunit 1ns;
	timeprecision 100ps;

	import perf_pkg::*;

	localparam int LEN = `PERF_RECORD_LEN;
	localparam int NUM_RECORDS = 6;
	// strobe sits in cycle PERIOD, byte 0 follows and is seen one edge later
	localparam int FIRST_START = `PERF_REPORT_PERIOD + 2;

	localparam logic [8*LEN-1:0] IDLE_RECORD  = "a000000b000000c000000";
	localparam logic [8*LEN-1:0] PULSE_RECORD = "a01F02Ab00B00Cc00D00E";

	cache_events_t    prev_ev;
	perf_counts_t     model_cnt;
	perf_counts_t     cnt_last_edge;
	logic [8*LEN-1:0] exp_rec;
	logic             in_rec;
	logic             tail_check;
	int               cyc;
	int               rec_idx;
	int               byte_idx;
	int               rec_errs;
	int               last_start;
	int unsigned      pass_cnt;

	function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
		if (nib < 4'd10)
			return "0" + nib;
		return "A" + (nib - 4'd10);
	endfunction

	function automatic logic [23:0] hex3(input logic [`PERF_CNT_W-1:0] v);
		return {hex_ascii(v[11:8]), hex_ascii(v[7:4]), hex_ascii(v[3:0])};
	endfunction

	// reference record, access sums cut to counter width
	function automatic logic [8*LEN-1:0] expected_record(input perf_counts_t c);
		logic [`PERF_CNT_W-1:0] l1d_acc;
		logic [`PERF_CNT_W-1:0] l2_acc;
		l1d_acc = c.l1d_read + c.l1d_write;
		l2_acc  = c.l2_read + c.l2_write;
		return {"a", hex3(c.l1i_miss), hex3(c.l1i_read),
			"b", hex3(c.l1d_miss), hex3(l1d_acc),
			"c", hex3(c.l2_miss), hex3(l2_acc)};
	endfunction

	function automatic perf_counts_t count_rises(input perf_counts_t c, input cache_events_t r);
		perf_counts_t n;
		n.l1i_read  = c.l1i_read + r.l1i_read;
		n.l1i_miss  = c.l1i_miss + r.l1i_miss;
		n.l1d_read  = c.l1d_read + r.l1d_read;
		n.l1d_write = c.l1d_write + r.l1d_write;
		n.l1d_miss  = c.l1d_miss + r.l1d_miss;
		n.l2_read   = c.l2_read + r.l2_read;
		n.l2_write  = c.l2_write + r.l2_write;
		n.l2_miss   = c.l2_miss + r.l2_miss;
		return n;
	endfunction

	task automatic note_fail();
		fail_cnt_o++;
		rec_errs++;
	endtask

	task automatic close_record();
		in_rec = 1'b0;
		if (rec_errs == 0)
			$display("record %0d of %0d passed", rec_idx + 1, NUM_RECORDS);
		else
			$display("record %0d of %0d failed with %0d errors", rec_idx + 1, NUM_RECORDS,
				rec_errs);
		rec_idx++;
		if (rec_idx == NUM_RECORDS)
			tail_check = 1'b1;
	endtask

	always @(posedge clk) begin : watch
		cache_events_t rise;
		int            exp_start;
		if (!rstn) begin
			prev_ev       = '0;
			model_cnt     = '0;
			cnt_last_edge = '0;
			exp_rec       = '0;
			in_rec        = 1'b0;
			tail_check    = 1'b0;
			cyc           = 0;
			rec_idx       = 0;
			byte_idx      = 0;
			rec_errs      = 0;
			last_start    = 0;
			pass_cnt      = 0;
			fail_cnt_o    = 0;
			done_o        = 1'b0;
		end else begin
			cyc = cyc + 1;
			if (done_o) begin
				// nothing left to check
			end else if (tail_check) begin
				tail_check = 1'b0;
				if (beat_i.valid) begin
					fail_cnt_o++;
					$display("last record is longer than %0d bytes", LEN);
				end else begin
					pass_cnt++;
				end
				$display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt_o);
				done_o = 1'b1;
			end else if (beat_i.valid) begin
				if (!in_rec) begin
					rec_errs  = 0;
					exp_start = (rec_idx == 0) ? FIRST_START : last_start + `PERF_REPORT_PERIOD;
					if (cyc != exp_start) begin
						note_fail();
						$display("record %0d started at cycle %0d, expected cycle %0d",
							rec_idx + 1, cyc, exp_start);
					end else begin
						pass_cnt++;
					end
					last_start = cyc;
					// the record was launched one edge before valid is seen here
					exp_rec  = expected_record(cnt_last_edge);
					in_rec   = 1'b1;
					byte_idx = 0;
					// idle lines give a fixed first record
					if (rec_idx == 0)
						exp_rec = IDLE_RECORD;
					if (rec_idx == 1 && exp_rec != PULSE_RECORD) begin
						note_fail();
						$display("pulse counts do not give the known second record");
					end
				end
				if (beat_i.data !== exp_rec[8*(LEN-1-byte_idx) +: 8]) begin
					note_fail();
					$display("FAIL t=%0t record %0d byte %0d expected 0x%02h got 0x%02h",
						$time, rec_idx + 1, byte_idx, exp_rec[8*(LEN-1-byte_idx) +: 8],
						beat_i.data);
				end else begin
					pass_cnt++;
				end
				byte_idx++;
				if (byte_idx == LEN)
					close_record();
			end else if (in_rec) begin
				note_fail();
				$display("record %0d stopped after %0d of %0d bytes, valid dropped early",
					rec_idx + 1, byte_idx, LEN);
				close_record();
			end

			// model update, after the beat check of this edge
			rise          = events_i & ~prev_ev;
			cnt_last_edge = model_cnt;
			model_cnt     = count_rises(model_cnt, rise);
			prev_ev       = events_i;
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_cache_perf_monitor.sv
`default_nettype none

module tb_cache_perf_monitor;

	timeunit 1ns;
	timeprecision 100ps;

	import perf_pkg::*;

	// six records of 120 cycles plus reset come to about 750, rest is margin
	localparam int TIMEOUT_CYCLES = 1000;

	logic          clk;
	logic          rstn;
	cache_events_t events;
	report_beat_t  beat;
	logic          done;
	int unsigned   fail_cnt;
	integer        seed;
	logic [31:0]   rnd;
	int            cycles;

	// pulse schedule per line, index is the bit in cache_events_t
	int pulse_left [8];
	int hold_len [8];
	int phase [8];

	cache_perf_monitor cache_perf_monitor_inst (
		.clk      (clk),
		.rstn     (rstn),
		.events_i (events),
		.beat_o   (beat)
	);

	perf_checker perf_checker_inst (
		.clk        (clk),
		.rstn       (rstn),
		.events_i   (events),
		.beat_i     (beat),
		.done_o     (done),
		.fail_cnt_o (fail_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic wait_record_start();
		do @(posedge clk); while (beat.valid);
		do @(posedge clk); while (!beat.valid);
	endtask

	task automatic set_pulse(input int line, input int count, input int hold);
		pulse_left[line] = count;
		hold_len[line]   = hold;
		phase[line]      = 0;
	endtask

	// each pulse is hold cycles high then one cycle low
	task automatic run_pulses();
		logic [7:0] bits;
		logic       busy;
		busy = 1'b1;
		while (busy) begin
			@(posedge clk);
			busy = 1'b0;
			for (int i = 0; i < 8; i++) begin
				bits[i] = 1'b0;
				if (pulse_left[i] > 0) begin
					busy = 1'b1;
					if (phase[i] < hold_len[i]) begin
						bits[i] = 1'b1;
						phase[i]++;
					end else begin
						phase[i] = 0;
						pulse_left[i]--;
					end
				end
			end
			events <= cache_events_t'(bits);
		end
	endtask

	initial begin
		seed   = 32'h27651d1a;
		rnd    = '0;
		rstn   = 1'b0;
		events = '0;
		repeat (5) @(posedge clk);
		rstn <= 1'b1;

		// all lines stay low up to the first record
		wait_record_start();

		// counts chosen so the next record shows every letter A to F
		set_pulse(7, 42, 1);
		set_pulse(6, 31, 2);
		set_pulse(5, 6, 4);
		set_pulse(4, 6, 1);
		set_pulse(3, 11, 3);
		set_pulse(2, 8, 3);
		set_pulse(1, 6, 2);
		set_pulse(0, 13, 5);
		run_pulses();

		wait_record_start();
		// random toggling until the checker has seen every record
		while (!done) begin
			@(posedge clk);
			rnd = $random(seed);
			events <= cache_events_t'(rnd[7:0]);
		end

		if (fail_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("run timed out after %0d cycles before all records arrived", cycles);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
